/* include/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data path and byte address width.
`define XLEN 32

// Register index width for 32 architectural registers.
`define REG_ADDR_W 5

// Depth of the unified word memory.
`define MEM_WORDS 1024

// Word address width. Byte address bits 11:2 select the word.
`define MEM_ADDR_W 10

`endif

/* rv_soc.f */
+incdir+include
src/rv_pkg.sv
src/core_ifs.sv
src/mem_arbiter.sv
src/unified_ram.sv
src/fetch_unit.sv
src/rv_decoder.sv
src/rv_core.sv
src/rv_soc.sv
tb/clk_gen.sv
tb/rv_soc_tb.sv

/* src/core_ifs.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

// Valid/ready request channel with a fixed one cycle response.
interface mem_if;
  logic              valid;
  logic              ready;
  rv_pkg::memReqT    req;
  logic              rvalid;  // Pulses one cycle after each accepted request.
  logic [`XLEN-1:0]  rdata;

  modport requester (output valid, output req, input ready, input rvalid, input rdata);
  modport responder (input valid, input req, output ready, output rvalid, output rdata);
endinterface

// Instruction hand-off from the fetch unit to the core, plus the redirect path back.
interface fetch_if;
  logic              instrValid;
  logic              instrReady;
  logic [`XLEN-1:0]  instr;
  logic [`XLEN-1:0]  pc;
  logic              redirect;    // One cycle pulse.
  logic [`XLEN-1:0]  redirectPc;

  modport fetcher (output instrValid, output instr, output pc,
                   input instrReady, input redirect, input redirectPc);
  modport core (input instrValid, input instr, input pc,
                output instrReady, output redirect, output redirectPc);
endinterface

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module fetch_unit (
  input logic      clk,
  input logic      arstN,
  input logic      run,
  mem_if.requester memPort,
  fetch_if.fetcher core
);

  logic [`XLEN-1:0] pcQ;           // Address being fetched or of the held word.
  logic [`XLEN-1:0] instrQ;
  logic [`XLEN-1:0] redirPcQ;
  logic             instrValidQ;
  logic             outstandingQ;  // Response returns this cycle.
  logic             dropQ;         // Next response belongs to a stale path.
  logic             staleQ;        // Waiting request was overtaken by a redirect.
  logic             fire;
  logic             takeInstr;

  assign memPort.valid = run && !instrValidQ && !outstandingQ;
  assign memPort.req   = '{write: 1'b0, addr: pcQ[`MEM_ADDR_W+1:2], wdata: '0};
  assign fire          = memPort.valid && memPort.ready;
  assign takeInstr     = core.instrValid && core.instrReady;

  assign core.instrValid = instrValidQ;
  assign core.instr      = instrQ;
  assign core.pc         = pcQ;

  always_ff @(posedge clk) begin
    if (memPort.rvalid) instrQ <= memPort.rdata;
    if (core.redirect) redirPcQ <= core.redirectPc;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcQ          <= '0;
      instrValidQ  <= 1'b0;
      outstandingQ <= 1'b0;
      dropQ        <= 1'b0;
      staleQ       <= 1'b0;
    end else begin
      outstandingQ <= fire;  // Memory latency is exactly one cycle.
      if (takeInstr) begin
        instrValidQ <= 1'b0;
        pcQ         <= pcQ + `XLEN'd4;
      end else if (memPort.rvalid && !dropQ && !core.redirect) begin
        instrValidQ <= 1'b1;
      end
      if (memPort.rvalid) dropQ <= 1'b0;
      if (core.redirect) begin
        if (memPort.valid && !memPort.ready) begin
          staleQ <= 1'b1;  // Request must stay stable, so the jump waits for it.
        end else begin
          pcQ   <= core.redirectPc;
          dropQ <= fire;
        end
      end else if (staleQ && fire) begin
        staleQ <= 1'b0;
        pcQ    <= redirPcQ;
        dropQ  <= 1'b1;
      end
    end
  end

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
  parameter type reqT = rv_pkg::memReqT
) (
  input logic      clk,
  input logic      arstN,
  mem_if.responder hostPort,
  mem_if.responder dataPort,
  mem_if.responder fetchPort,
  mem_if.requester memPort
);

  localparam logic [1:0] TAG_NONE  = 2'd0;
  localparam logic [1:0] TAG_HOST  = 2'd1;
  localparam logic [1:0] TAG_DATA  = 2'd2;
  localparam logic [1:0] TAG_FETCH = 2'd3;

  logic [2:0] grant;  // Bit 0 host, bit 1 data, bit 2 fetch.
  logic [1:0] tagD;
  logic [1:0] tagQ;   // Owner of the response due this cycle.
  reqT        winReq;

  always_comb begin
    grant  = 3'b000;
    tagD   = TAG_NONE;
    winReq = fetchPort.req;
    if (hostPort.valid) begin  // Host loading always wins.
      grant  = 3'b001;
      tagD   = TAG_HOST;
      winReq = hostPort.req;
    end else if (dataPort.valid) begin
      grant  = 3'b010;
      tagD   = TAG_DATA;
      winReq = dataPort.req;
    end else if (fetchPort.valid) begin
      grant = 3'b100;
      tagD  = TAG_FETCH;
    end
  end

  assign memPort.valid   = |grant;
  assign memPort.req     = winReq;
  assign hostPort.ready  = grant[0] && memPort.ready;  // Losers see ready low and hold.
  assign dataPort.ready  = grant[1] && memPort.ready;
  assign fetchPort.ready = grant[2] && memPort.ready;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      tagQ <= TAG_NONE;
    end else begin
      tagQ <= (memPort.valid && memPort.ready) ? tagD : TAG_NONE;
    end
  end

  assign hostPort.rvalid  = memPort.rvalid && (tagQ == TAG_HOST);
  assign dataPort.rvalid  = memPort.rvalid && (tagQ == TAG_DATA);
  assign fetchPort.rvalid = memPort.rvalid && (tagQ == TAG_FETCH);
  assign hostPort.rdata   = memPort.rdata;  // Qualified by the routed rvalid.
  assign dataPort.rdata   = memPort.rdata;
  assign fetchPort.rdata  = memPort.rdata;

  grantOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot0(grant));

  rvalidToGranted: assert property (@(posedge clk) disable iff (!arstN)
    ({fetchPort.rvalid, dataPort.rvalid, hostPort.rvalid} != 3'b000) |->
    ({fetchPort.rvalid, dataPort.rvalid, hostPort.rvalid} ==
      $past(grant & {3{memPort.ready}})));

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
  input  logic             clk,
  input  logic             arstN,
  fetch_if.core            fetch,
  mem_if.requester         memPort,
  output logic [`XLEN-1:0] a0,
  output logic             halted
);

  typedef enum logic [1:0] {IDLE, EXEC, MEM_WAIT} stateT;

  localparam int A0_REG = 10;

  stateT            state;
  rv_pkg::decodedT  dec;
  logic [`XLEN-1:0] instrQ;
  logic [`XLEN-1:0] pcQ;
  logic [`XLEN-1:0] regs [32];
  logic [`XLEN-1:0] rs1Val;
  logic [`XLEN-1:0] rs2Val;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] wbData;
  logic             wbEn;
  logic             memOp;
  logic             taken;
  logic             haltedQ;

  rv_decoder uDecoder (.instr(instrQ), .dec(dec));

  assign rs1Val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];  // x0 reads as zero.
  assign rs2Val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
  assign opB    = dec.useImm ? dec.imm : rs2Val;
  assign memOp  = dec.isLoad || dec.isStore;
  assign taken  = dec.branchNe ? (rs1Val != rs2Val) : (rs1Val == rs2Val);

  always_comb begin
    case (dec.aluOp)
      rv_pkg::SUB: aluResult = rs1Val - opB;
      rv_pkg::AND: aluResult = rs1Val & opB;
      rv_pkg::OR:  aluResult = rs1Val | opB;
      rv_pkg::XOR: aluResult = rs1Val ^ opB;
      rv_pkg::SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(rs1Val) < $signed(opB)};
      default:     aluResult = rs1Val + opB;
    endcase
  end

  assign fetch.instrReady = (state == IDLE);  // A halted core never leaves EXEC.
  assign fetch.redirect   = (state == EXEC) && (dec.isJal || (dec.isBranch && taken));
  assign fetch.redirectPc = pcQ + dec.imm;

  assign memPort.valid = (state == EXEC) && memOp;
  assign memPort.req   = '{write: dec.isStore, addr: aluResult[`MEM_ADDR_W+1:2], wdata: rs2Val};

  assign wbEn   = ((state == EXEC) && !memOp && dec.regWrite)
                || ((state == MEM_WAIT) && memPort.rvalid && dec.isLoad);
  assign wbData = (state == MEM_WAIT) ? memPort.rdata :
                  dec.isJal ? pcQ + `XLEN'd4 :
                  dec.isLui ? dec.imm : aluResult;

  always_ff @(posedge clk) begin
    if (fetch.instrValid && fetch.instrReady) begin
      instrQ <= fetch.instr;
      pcQ    <= fetch.pc;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regs <= '{default: '0};
    end else if (wbEn && dec.rd != '0) begin
      regs[dec.rd] <= wbData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= IDLE;
      haltedQ <= 1'b0;
    end else begin
      case (state)
        IDLE: if (fetch.instrValid) state <= EXEC;
        EXEC: begin
          if (dec.isHalt || dec.illegal) begin
            haltedQ <= 1'b1;  // Stay in EXEC until reset.
          end else if (memOp) begin
            if (memPort.ready) state <= MEM_WAIT;  // Stall while arbitration is lost.
          end else begin
            state <= IDLE;
          end
        end
        MEM_WAIT: if (memPort.rvalid) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign a0     = regs[A0_REG];
  assign halted = haltedQ;

  noFetchWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
    haltedQ |-> !fetch.instrReady);

  noMemWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
    haltedQ |-> !memPort.valid);

endmodule

/* src/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decoder (
  input  logic [`XLEN-1:0] instr,
  output rv_pkg::decodedT  dec
);

  rv_pkg::opcodeT   opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;

  assign opcode = rv_pkg::opcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec       = '0;
    dec.rs1   = instr[19:15];
    dec.rs2   = instr[24:20];
    dec.rd    = instr[11:7];
    dec.aluOp = rv_pkg::ADD;  // Address and link arithmetic use ADD.
    case (opcode)
      rv_pkg::OP: begin
        case (funct3)
          3'b000: begin
            if (funct7[5]) dec.aluOp = rv_pkg::SUB;
          end
          3'b111: dec.aluOp = rv_pkg::AND;
          3'b110: dec.aluOp = rv_pkg::OR;
          3'b100: dec.aluOp = rv_pkg::XOR;
          3'b010: dec.aluOp = rv_pkg::SLT;
          default: dec.illegal = 1'b1;
        endcase
        if (funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 == 3'b000)) dec.illegal = 1'b1;
        dec.regWrite = !dec.illegal;
      end
      rv_pkg::OP_IMM: begin  // ADDI only.
        dec.imm      = immI;
        dec.useImm   = 1'b1;
        dec.illegal  = (funct3 != 3'b000);
        dec.regWrite = !dec.illegal;
      end
      rv_pkg::LUI: begin
        dec.imm      = immU;
        dec.isLui    = 1'b1;
        dec.regWrite = 1'b1;
      end
      rv_pkg::LOAD: begin  // Word loads only.
        dec.imm      = immI;
        dec.useImm   = 1'b1;
        dec.illegal  = (funct3 != 3'b010);
        dec.isLoad   = !dec.illegal;
        dec.regWrite = !dec.illegal;
      end
      rv_pkg::STORE: begin
        dec.imm     = immS;
        dec.useImm  = 1'b1;
        dec.illegal = (funct3 != 3'b010);
        dec.isStore = !dec.illegal;
      end
      rv_pkg::BRANCH: begin
        dec.imm      = immB;
        dec.illegal  = (funct3[2:1] != 2'b00);
        dec.isBranch = !dec.illegal;
        dec.branchNe = funct3[0];
      end
      rv_pkg::JAL: begin
        dec.imm      = immJ;
        dec.isJal    = 1'b1;
        dec.regWrite = 1'b1;
      end
      rv_pkg::SYSTEM: begin
        if (instr[31:7] == '0) dec.isHalt = 1'b1;  // ECALL.
        else dec.illegal = 1'b1;
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

/* src/rv_pkg.sv */
`include "rv_cfg.svh"

package rv_pkg;

  // Major opcode groups of the supported RV32I subset.
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcodeT;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLT = 3'd5
  } aluOpT;

  // One word request toward the unified memory.
  typedef struct packed {
    logic                   write;
    logic [`MEM_ADDR_W-1:0] addr;  // Word address.
    logic [`XLEN-1:0]       wdata;
  } memReqT;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    aluOpT                  aluOp;
    logic [`XLEN-1:0]       imm;       // Already sign extended.
    logic                   useImm;    // Second ALU operand is the immediate.
    logic                   regWrite;
    logic                   isLoad;
    logic                   isStore;
    logic                   isBranch;
    logic                   branchNe;  // Set for BNE and clear for BEQ.
    logic                   isJal;
    logic                   isLui;
    logic                   isHalt;
    logic                   illegal;
  } decodedT;

endpackage

/* src/rv_soc.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_soc (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   run,
  input  logic                   hostValid,
  output logic                   hostReady,
  input  logic                   hostWrite,
  input  logic [`MEM_ADDR_W-1:0] hostAddr,
  input  logic [`XLEN-1:0]       hostWdata,
  output logic                   hostRvalid,
  output logic [`XLEN-1:0]       hostRdata,
  output logic [`XLEN-1:0]       a0,
  output logic                   halted
);

  mem_if   hostBus ();
  mem_if   dataBus ();
  mem_if   fetchBus ();
  mem_if   ramBus ();
  fetch_if fetchLink ();

  // Host port enters the arbiter as its own requester.
  assign hostBus.valid = hostValid;
  assign hostBus.req   = '{write: hostWrite, addr: hostAddr, wdata: hostWdata};
  assign hostReady     = hostBus.ready;
  assign hostRvalid    = hostBus.rvalid;
  assign hostRdata     = hostBus.rdata;

  mem_arbiter #(.reqT(rv_pkg::memReqT)) uArbiter (
    .clk      (clk),
    .arstN    (arstN),
    .hostPort (hostBus),
    .dataPort (dataBus),
    .fetchPort(fetchBus),
    .memPort  (ramBus)
  );

  unified_ram uRam (.clk(clk), .arstN(arstN), .port(ramBus));

  fetch_unit uFetch (.clk(clk), .arstN(arstN), .run(run), .memPort(fetchBus), .core(fetchLink));

  rv_core uCore (
    .clk    (clk),
    .arstN  (arstN),
    .fetch  (fetchLink),
    .memPort(dataBus),
    .a0     (a0),
    .halted (halted)
  );

endmodule

/* src/unified_ram.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module unified_ram (
  input logic      clk,
  input logic      arstN,
  mem_if.responder port
);

  logic [`XLEN-1:0] mem [`MEM_WORDS];
  logic             accept;

  assign port.ready = 1'b1;  // Never back-pressures.
  assign accept     = port.valid && port.ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      if (port.req.write) begin
        mem[port.req.addr] <= port.req.wdata;
      end else begin
        port.rdata <= mem[port.req.addr];  // Read word lands with rvalid.
      end
    end
  end

  // Writes get an rvalid as well so that every requester can count responses.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      port.rvalid <= 1'b0;
    end else begin
      port.rvalid <= accept;
    end
  end

  addrInRange: assert property (@(posedge clk) disable iff (!arstN)
    port.valid |-> (32'(port.req.addr) < `MEM_WORDS));

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
  parameter real PERIOD       = 40.0,
  parameter int  RESET_CYCLES = 3
) (
  input  logic resetReq,
  output logic clk,
  output logic arstN
);

  initial clk = 1'b0;
  always #(PERIOD / 2.0) clk = ~clk;

  initial begin
    forever begin
      arstN = 1'b0;  // Start-up reset, and again on every rising resetReq.
      repeat (RESET_CYCLES) @(negedge clk);
      arstN = 1'b1;
      @(posedge resetReq);
    end
  end

endmodule

/* tb/rv_soc_tb.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_soc_tb;

  localparam int HOST_TIMEOUT  = 100;
  localparam int HALT_TIMEOUT  = 4000;
  localparam int RESET_TIMEOUT = 20;
  localparam int MODEL_STEPS   = 1000;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

  logic                   clk;
  logic                   arstN;
  logic                   resetReq;
  logic                   run;
  logic                   hostValid;
  logic                   hostReady;
  logic                   hostWrite;
  logic [`MEM_ADDR_W-1:0] hostAddr;
  logic [`XLEN-1:0]       hostWdata;
  logic                   hostRvalid;
  logic [`XLEN-1:0]       hostRdata;
  logic [`XLEN-1:0]       a0;
  logic                   halted;

  int          errors;
  int          testsRun;
  int          testsFailed;
  int          testErrStart;
  string       curTest;
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [`MEM_WORDS];  // Mirrors every host write and every modelled store.
  logic [31:0] prog [$];
  int          touched [$];             // Data words written by the current program.

  clk_gen uClkGen (.resetReq(resetReq), .clk(clk), .arstN(arstN));

  rv_soc u_dut (
    .clk       (clk),
    .arstN     (arstN),
    .run       (run),
    .hostValid (hostValid),
    .hostReady (hostReady),
    .hostWrite (hostWrite),
    .hostAddr  (hostAddr),
    .hostWdata (hostWdata),
    .hostRvalid(hostRvalid),
    .hostRdata (hostRdata),
    .a0        (a0),
    .halted    (halted)
  );

  function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] randAlu();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int         kind;
    rd   = 5'($urandom_range(31, 0));  // x0 is a legal target and must stay zero.
    rs1  = 5'($urandom_range(31, 0));
    rs2  = 5'($urandom_range(31, 0));
    kind = $urandom_range(7, 0);
    case (kind)
      0: return encR(7'h00, rs2, rs1, 3'b000, rd);
      1: return encR(7'h20, rs2, rs1, 3'b000, rd);
      2: return encR(7'h00, rs2, rs1, 3'b111, rd);
      3: return encR(7'h00, rs2, rs1, 3'b110, rd);
      4: return encR(7'h00, rs2, rs1, 3'b100, rd);
      5: return encR(7'h00, rs2, rs1, 3'b010, rd);
      6: return encI(12'($urandom), rs1, 3'b000, rd, OPC_IMM);
      default: return {20'($urandom), rd, OPC_LUI};
    endcase
  endfunction

  task automatic pushMixed();
    int          k;
    int          kind;
    logic [11:0] off;
    k    = $urandom_range(15, 0);
    off  = 12'h800 + 12'(4 * k);  // x0 plus this offset lands on word 512 + k.
    kind = $urandom_range(2, 0);
    if (kind == 0) begin
      prog.push_back(encS(off, 5'($urandom_range(31, 0)), 5'd0));
      touched.push_back(512 + k);
    end else if (kind == 1) begin
      prog.push_back(encI(off, 5'd0, 3'b010, 5'($urandom_range(31, 1)), OPC_LOAD));
    end else begin
      prog.push_back(randAlu());
    end
  endtask

  task automatic pushFinal();
    prog.push_back(encR(7'h00, 5'd0, 5'($urandom_range(31, 1)), 3'b000, 5'd10));
    prog.push_back(ECALL_WORD);
  endtask

  task automatic noteFailure(string msg);
    errors++;
    $display("%s: %s", curTest, msg);
  endtask

  task automatic checkWord(string what, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", curTest, what, exp, act);
    end
  endtask

  task automatic startTest(string name);
    curTest      = name;
    testErrStart = errors;
    testsRun++;
  endtask

  task automatic endTest();
    if (errors > testErrStart) begin
      testsFailed++;
      $display("test %s: %0d errors", curTest, errors - testErrStart);
    end else begin
      $display("test %s: ok", curTest);
    end
  endtask

  task automatic waitResetRelease();
    int n;
    n = 0;
    while (!arstN && n < RESET_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (arstN) else noteFailure("reset was not released in time");
  endtask

  task automatic applyReset();
    @(negedge clk);
    run      = 1'b0;
    resetReq = 1'b1;
    @(negedge clk);
    resetReq = 1'b0;
    waitResetRelease();
  endtask

  task automatic hostAccess(input logic write, input int addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output bit ok);
    int waitCycles;
    ok    = 1'b0;
    rdata = '0;
    @(negedge clk);
    hostValid = 1'b1;
    hostWrite = write;
    hostAddr  = addr[`MEM_ADDR_W-1:0];
    hostWdata = wdata;
    #1;  // Ready is combinational on the request, so it is read mid-cycle.
    waitCycles = 0;
    while (!hostReady && waitCycles < HOST_TIMEOUT) begin
      @(negedge clk);
      #1;
      waitCycles++;
    end
    if (!hostReady) begin
      @(negedge clk);
      hostValid = 1'b0;
      noteFailure("the host request was never accepted");
      return;
    end
    @(negedge clk);  // The rising edge in between took the request.
    hostValid  = 1'b0;
    waitCycles = 0;
    while (!hostRvalid && waitCycles < HOST_TIMEOUT) begin
      @(negedge clk);
      waitCycles++;
    end
    assert (hostRvalid) else begin
      noteFailure("no host response arrived after an accepted request");
      return;
    end
    assert (waitCycles == 0) else
      noteFailure($sformatf("host response came %0d cycles late", waitCycles));
    rdata = hostRdata;
    ok    = 1'b1;
  endtask

  task automatic writeWord(int addr, logic [31:0] data);
    logic [31:0] unused;
    bit          ok;
    hostAccess(1'b1, addr, data, unused, ok);
    modelMem[addr] = data;
  endtask

  task automatic readCheck(int addr);
    logic [31:0] data;
    bit          ok;
    hostAccess(1'b0, addr, '0, data, ok);
    if (ok) checkWord($sformatf("word %0d", addr), modelMem[addr], data);
  endtask

  task automatic modelRun(output bit ok);
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] immI;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [4:0]  rd;
    bit          wr;
    bit          done;
    int          steps;
    modelRegs = '{default: '0};
    pc        = '0;
    done      = 1'b0;
    steps     = 0;
    while (!done && steps < MODEL_STEPS) begin
      instr  = modelMem[pc[11:2]];
      a      = modelRegs[instr[19:15]];
      b      = modelRegs[instr[24:20]];
      rd     = instr[11:7];
      immI   = {{20{instr[31]}}, instr[31:20]};
      immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      nextPc = pc + 32'd4;
      wr     = 1'b1;
      res    = '0;
      case (instr[6:0])
        OPC_OP: begin
          case (instr[14:12])
            3'b000: res = instr[30] ? a - b : a + b;
            3'b111: res = a & b;
            3'b110: res = a | b;
            3'b100: res = a ^ b;
            default: res = {31'b0, $signed(a) < $signed(b)};
          endcase
        end
        OPC_IMM: res = a + immI;
        OPC_LUI: res = {instr[31:12], 12'b0};
        OPC_LOAD: begin
          ea  = a + immI;
          res = modelMem[ea[11:2]];
        end
        OPC_STORE: begin
          ea = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
          modelMem[ea[11:2]] = b;
          wr = 1'b0;
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          if (instr[12] ? (a != b) : (a == b)) nextPc = pc + immB;
        end
        OPC_JAL: begin
          res    = pc + 32'd4;
          nextPc = pc + immJ;
        end
        default: begin  // ECALL, and anything else stops the core too.
          wr   = 1'b0;
          done = 1'b1;
        end
      endcase
      if (wr && rd != 5'd0) modelRegs[rd] = res;
      pc = nextPc;
      steps++;
    end
    ok = done;
  endtask

  task automatic startProgram();
    bit ok;
    applyReset();
    for (int i = 0; i < prog.size(); i++) writeWord(i, prog[i]);
    modelRun(ok);
    assert (ok) else noteFailure("the model ran out of steps before ECALL");
    @(negedge clk);
    run = 1'b1;
  endtask

  task automatic waitHalted(output bit ok);
    int n;
    n = 0;
    while (!halted && n < HALT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = halted;
    assert (halted) else noteFailure("the core did not halt in time");
  endtask

  task automatic executeProgram();
    bit ok;
    startProgram();
    waitHalted(ok);
    if (ok) checkWord("a0", modelRegs[10], a0);
  endtask

  initial begin
    bit          ok;
    int          m;
    logic [11:0] r1;
    resetReq  = 1'b0;
    run       = 1'b0;
    hostValid = 1'b0;
    hostWrite = 1'b0;
    hostAddr  = '0;
    hostWdata = '0;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    void'($urandom(32'h8bef_39ce));
    @(negedge clk);
    waitResetRelease();

    startTest("host_load");
    for (int w = 512; w < `MEM_WORDS; w++) writeWord(w, $urandom);
    repeat (64) readCheck($urandom_range(`MEM_WORDS - 1, 512));
    endTest();

    startTest("alu");
    repeat (3) begin
      prog.delete();
      prog.push_back(encI(12'h5a5, 5'd0, 3'b000, 5'd0, OPC_IMM));  // Write to x0.
      repeat (24) prog.push_back(randAlu());
      pushFinal();
      executeProgram();
    end
    endTest();

    startTest("load_store");
    repeat (3) begin
      prog.delete();
      touched.delete();
      repeat (6) prog.push_back(randAlu());
      repeat (24) pushMixed();
      pushFinal();
      executeProgram();
      foreach (touched[i]) readCheck(touched[i]);
    end
    endTest();

    startTest("control_flow");
    repeat (4) begin
      prog.delete();
      r1 = 12'($urandom);
      m  = $urandom_range(5, 1);
      prog.push_back(encI(r1, 5'd0, 3'b000, 5'd1, OPC_IMM));
      prog.push_back(encI($urandom_range(1, 0) ? r1 : 12'($urandom), 5'd0, 3'b000, 5'd2,
                          OPC_IMM));
      prog.push_back(encI(12'($urandom), 5'd0, 3'b000, 5'd10, OPC_IMM));
      prog.push_back(encB(13'(4 * (m + 1)), 5'd2, 5'd1, 3'($urandom_range(1, 0))));
      repeat (m) prog.push_back(encI(12'($urandom), 5'd10, 3'b000, 5'd10, OPC_IMM));
      prog.push_back(encI(12'($urandom), 5'd10, 3'b000, 5'd10, OPC_IMM));
      prog.push_back(encJ(21'd8, 5'd5));
      prog.push_back(encI(12'h3e8, 5'd10, 3'b000, 5'd10, OPC_IMM));  // Jumped over.
      prog.push_back(encR(7'h00, 5'd5, 5'd10, 3'b000, 5'd10));       // Adds the link.
      prog.push_back(ECALL_WORD);
      executeProgram();
    end
    endTest();

    startTest("halt_contention");
    prog.delete();
    touched.delete();
    repeat (30) pushMixed();
    pushFinal();
    startProgram();
    fork
      waitHalted(ok);
      repeat (12) readCheck($urandom_range(`MEM_WORDS - 1, 768));  // Untouched words.
    join
    if (ok) begin
      checkWord("a0", modelRegs[10], a0);
      repeat (20) begin
        @(negedge clk);
        assert (halted) else noteFailure("halted dropped after ECALL");
        checkWord("a0 after halt", modelRegs[10], a0);
      end
    end
    endTest();

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
